/* logic/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// data path widths
`define WORD_WD       32
`define REG_ADDR_WD   5
`define EXC_CODE_WD   5
`define REG_NUM       32
`define REG_RA        5'd31        // jal link register

// primary opcodes
`define OP_SPECIAL    6'h00
`define OP_JAL        6'h03
`define OP_BEQ        6'h04
`define OP_BNE        6'h05
`define OP_ADDIU      6'h09
`define OP_LUI        6'h0f
`define OP_LW         6'h23
`define OP_SW         6'h2b

// funct codes under OP_SPECIAL
`define FN_SLL        6'h00
`define FN_SRL        6'h02
`define FN_SRA        6'h03
`define FN_JR         6'h08
`define FN_SYSCALL    6'h0c
`define FN_BREAK      6'h0d
`define FN_ADDU       6'h21
`define FN_SUBU       6'h23
`define FN_AND        6'h24
`define FN_OR         6'h25
`define FN_XOR        6'h26
`define FN_NOR        6'h27
`define FN_SLT        6'h2a
`define FN_SLTU       6'h2b

// cp0 cause codes
`define EXC_INT       5'h00
`define EXC_SYS       5'h08
`define EXC_BP        5'h09
`define EXC_RI        5'h0a

// one-hot alu operation bits
`define ALU_OP_WD     12
`define ALU_ADD       0
`define ALU_SUB       1
`define ALU_SLT       2
`define ALU_SLTU      3
`define ALU_AND       4
`define ALU_NOR       5
`define ALU_OR        6
`define ALU_XOR       7
`define ALU_SLL       8
`define ALU_SRL       9
`define ALU_SRA       10
`define ALU_LUI       11

// second operand select
`define SRC2_REG      2'b00
`define SRC2_ZIMM     2'b01
`define SRC2_SIMM     2'b10

`define NUM_BYPASS    3            // execute, memory, writeback

`endif

/* logic/decode_pkg.sv */
`default_nettype none
`include "decode_consts.svh"

package decode_pkg;

    typedef logic [`WORD_WD-1:0]     word_t;
    typedef logic [`REG_ADDR_WD-1:0] reg_addr_t;
    typedef logic [`EXC_CODE_WD-1:0] exc_code_t;
    typedef logic [`ALU_OP_WD-1:0]   alu_op_t;
    typedef logic [1:0]              src2_sel_t;   // reg, zero-ext imm, sign-ext imm

    // fetch stage output, 71 bits
    typedef struct packed {
        logic      ex;
        exc_code_t exc_code;
        logic      bd;          // in a delay slot
        word_t     inst;
        word_t     pc;
    } fetch_bus_t;

    typedef struct packed {
        reg_addr_t dest;        // 0 when the stage writes nothing
        word_t     result;
    } bypass_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_write_t;

    typedef struct packed {
        logic       ie;
        logic       exl;
        logic [7:0] im;
        logic [7:0] ip;
    } cp0_int_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      load_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        src2_sel_t src2_sel;
        logic      src2_is_8;   // jal link offset
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        logic [15:0] imm;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
        logic      ex;
        exc_code_t exc_code;
        logic      bd;
    } ds_to_es_t;

    typedef enum logic [1:0] {
        IDLE,
        TAGGED,
        WAIT_CLEAR
    } int_state_t;

endpackage

`default_nettype wire

/* logic/inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_consts.svh"

module inst_decoder (
    input  wire decode_pkg::word_t inst,
    output decode_pkg::ctrl_t      ctrl,
    output logic                   uses_rs,
    output logic                   uses_rt,
    output logic                   reserved,
    output logic                   is_syscall,
    output logic                   is_break
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    decode_pkg::reg_addr_t rs;
    decode_pkg::reg_addr_t rt;
    decode_pkg::reg_addr_t rd;
    decode_pkg::reg_addr_t sa;
    logic                  special;
    logic                  r_alu;      // register form with sa field zero
    logic                  r_shift;    // shift form with rs field zero
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_addiu, inst_lui, inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_jal, inst_jr;
    logic                  writes_reg;
    logic                  dst_is_rt;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign sa     = inst[10:6];
    assign funct  = inst[5:0];

    assign special = (opcode == `OP_SPECIAL);
    assign r_alu   = special && (sa == '0);
    assign r_shift = special && (rs == '0);

    assign inst_addu  = r_alu && (funct == `FN_ADDU);
    assign inst_subu  = r_alu && (funct == `FN_SUBU);
    assign inst_slt   = r_alu && (funct == `FN_SLT);
    assign inst_sltu  = r_alu && (funct == `FN_SLTU);
    assign inst_and   = r_alu && (funct == `FN_AND);
    assign inst_or    = r_alu && (funct == `FN_OR);
    assign inst_xor   = r_alu && (funct == `FN_XOR);
    assign inst_nor   = r_alu && (funct == `FN_NOR);
    assign inst_sll   = r_shift && (funct == `FN_SLL);
    assign inst_srl   = r_shift && (funct == `FN_SRL);
    assign inst_sra   = r_shift && (funct == `FN_SRA);
    assign inst_jr    = r_alu && (funct == `FN_JR) && (rt == '0) && (rd == '0);
    assign inst_addiu = (opcode == `OP_ADDIU);
    assign inst_lui   = (opcode == `OP_LUI) && (rs == '0);
    assign inst_lw    = (opcode == `OP_LW);
    assign inst_sw    = (opcode == `OP_SW);
    assign inst_beq   = (opcode == `OP_BEQ);
    assign inst_bne   = (opcode == `OP_BNE);
    assign inst_jal   = (opcode == `OP_JAL);

    // code field of syscall and break is ignored
    assign is_syscall = special && (funct == `FN_SYSCALL);
    assign is_break   = special && (funct == `FN_BREAK);

    assign writes_reg = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or |
                        inst_xor | inst_nor | inst_sll | inst_srl | inst_sra |
                        inst_addiu | inst_lui | inst_lw | inst_jal;
    assign dst_is_rt  = inst_addiu | inst_lui | inst_lw;

    assign reserved = !(writes_reg | inst_sw | inst_beq | inst_bne | inst_jr |
                        is_syscall | is_break);

    // shifts take sa instead of rs
    assign uses_rs = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or |
                     inst_xor | inst_nor | inst_addiu | inst_lw | inst_sw |
                     inst_beq | inst_bne | inst_jr;
    assign uses_rt = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or |
                     inst_xor | inst_nor | inst_sll | inst_srl | inst_sra |
                     inst_sw | inst_beq | inst_bne;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[`ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        ctrl.alu_op[`ALU_SUB]  = inst_subu;
        ctrl.alu_op[`ALU_SLT]  = inst_slt;
        ctrl.alu_op[`ALU_SLTU] = inst_sltu;
        ctrl.alu_op[`ALU_AND]  = inst_and;
        ctrl.alu_op[`ALU_NOR]  = inst_nor;
        ctrl.alu_op[`ALU_OR]   = inst_or;
        ctrl.alu_op[`ALU_XOR]  = inst_xor;
        ctrl.alu_op[`ALU_SLL]  = inst_sll;
        ctrl.alu_op[`ALU_SRL]  = inst_srl;
        ctrl.alu_op[`ALU_SRA]  = inst_sra;
        ctrl.alu_op[`ALU_LUI]  = inst_lui;
        ctrl.load_op    = inst_lw;
        ctrl.src1_is_sa = inst_sll | inst_srl | inst_sra;
        ctrl.src1_is_pc = inst_jal;        // pc + 8 as link value
        ctrl.src2_is_8  = inst_jal;
        if (inst_lui) begin
            ctrl.src2_sel = `SRC2_ZIMM;
        end else if (inst_addiu | inst_lw | inst_sw) begin
            ctrl.src2_sel = `SRC2_SIMM;
        end else begin
            ctrl.src2_sel = `SRC2_REG;
        end
        ctrl.gr_we  = writes_reg;
        ctrl.mem_we = inst_sw;
        if (!writes_reg) begin
            ctrl.dest = '0;                // stores, branches, jr, traps
        end else if (inst_jal) begin
            ctrl.dest = `REG_RA;
        end else if (dst_is_rt) begin
            ctrl.dest = rt;
        end else begin
            ctrl.dest = rd;
        end
        ctrl.imm = inst[15:0];
    end

endmodule

`default_nettype wire

/* logic/register_file.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_consts.svh"

module register_file (
    input  wire                          clk,
    input  wire                          reset,
    input  wire decode_pkg::reg_addr_t   raddr1,
    input  wire decode_pkg::reg_addr_t   raddr2,
    output decode_pkg::word_t            rdata1,
    output decode_pkg::word_t            rdata2,
    input  wire decode_pkg::wb_write_t   wr
);

    decode_pkg::word_t regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && (wr.waddr != '0)) begin   // r0 stays zero
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // no write-through, writeback bypass covers the same cycle
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_write_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        wr.we |-> !$isunknown(wr.waddr)
    ) else $error("register write with unknown address");

endmodule

`default_nettype wire

/* logic/operand_forward.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_consts.svh"

module operand_forward (
    input  wire decode_pkg::reg_addr_t rs,
    input  wire decode_pkg::reg_addr_t rt,
    input  wire                        uses_rs,
    input  wire                        uses_rt,
    input  wire decode_pkg::word_t     rf_rs,
    input  wire decode_pkg::word_t     rf_rt,
    input  wire decode_pkg::bypass_t   bypass [`NUM_BYPASS],   // 0 is execute
    input  wire                        exe_load,
    output decode_pkg::word_t          rs_value,
    output decode_pkg::word_t          rt_value,
    output logic                       load_stall
);

    // a source hits a bypass entry; r0 never matches
    function automatic logic src_hit(
        input decode_pkg::reg_addr_t src,
        input logic                  used,
        input decode_pkg::reg_addr_t dest
    );
        return used && (src != '0) && (src == dest);
    endfunction

    // youngest matching result wins, else the register file
    function automatic decode_pkg::word_t pick(
        input decode_pkg::reg_addr_t src,
        input logic                  used,
        input decode_pkg::word_t     rf_value,
        input decode_pkg::bypass_t   bp [`NUM_BYPASS]
    );
        decode_pkg::word_t value;
        value = rf_value;
        for (int i = `NUM_BYPASS - 1; i >= 0; i--) begin   // oldest first, overwritten
            if (src_hit(src, used, bp[i].dest)) begin
                value = bp[i].result;
            end
        end
        return value;
    endfunction

    always_comb begin
        rs_value = pick(rs, uses_rs, rf_rs, bypass);
        rt_value = pick(rt, uses_rt, rf_rt, bypass);
    end

    // load result not ready until memory stage
    assign load_stall = exe_load &&
                        (src_hit(rs, uses_rs, bypass[0].dest) ||
                         src_hit(rt, uses_rt, bypass[0].dest));

endmodule

`default_nettype wire

/* logic/int_tag_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module int_tag_fsm (
    input  wire                         clk,
    input  wire                         reset,
    input  wire decode_pkg::cp0_int_t   cp0,
    input  wire                         stage_valid,
    input  wire                         handoff,     // item moves to execute
    output logic                        int_tag
);

    decode_pkg::int_state_t state;
    decode_pkg::int_state_t state_next;
    logic                   pending;

    assign pending = ((cp0.ip & cp0.im) != '0) && cp0.ie && !cp0.exl;

    always_comb begin
        state_next = state;
        int_tag    = 1'b0;
        case (state)
            decode_pkg::IDLE: begin
                if (pending && stage_valid) begin
                    int_tag = 1'b1;
                    // tagged item may leave in the same cycle
                    state_next = handoff ? decode_pkg::WAIT_CLEAR : decode_pkg::TAGGED;
                end
            end
            decode_pkg::TAGGED: begin
                int_tag = 1'b1;                  // hold until the item leaves
                if (handoff) begin
                    state_next = decode_pkg::WAIT_CLEAR;
                end
            end
            decode_pkg::WAIT_CLEAR: begin
                if (!pending) begin
                    state_next = decode_pkg::IDLE;
                end
            end
            default: begin
                state_next = decode_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= decode_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {decode_pkg::IDLE, decode_pkg::TAGGED, decode_pkg::WAIT_CLEAR}
    ) else $error("interrupt tag state at illegal encoding");

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_consts.svh"

module decode_stage (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          fs_valid,
    input  wire decode_pkg::fetch_bus_t  fs_bus,
    output logic                         allowin,
    input  wire                          es_allowin,
    output logic                         es_valid,
    output decode_pkg::ds_to_es_t        es_bus,
    input  wire decode_pkg::wb_write_t   wb_write,
    input  wire decode_pkg::bypass_t     bypass [`NUM_BYPASS],
    input  wire                          exe_load,
    input  wire decode_pkg::cp0_int_t    cp0,
    input  wire                          flush
);

    logic                   valid;
    decode_pkg::fetch_bus_t fs_r;          // latched fetch bundle
    decode_pkg::ctrl_t      ctrl;
    logic                   uses_rs;
    logic                   uses_rt;
    logic                   reserved;
    logic                   is_syscall;
    logic                   is_break;
    decode_pkg::word_t      rf_rs;
    decode_pkg::word_t      rf_rt;
    decode_pkg::word_t      rs_value;
    decode_pkg::word_t      rt_value;
    logic                   load_stall;
    logic                   ready_go;
    logic                   handoff;
    logic                   int_tag;
    decode_pkg::reg_addr_t  rs;
    decode_pkg::reg_addr_t  rt;

    assign rs = fs_r.inst[25:21];
    assign rt = fs_r.inst[20:16];

    assign ready_go = !load_stall;
    assign allowin  = !valid || (ready_go && es_allowin);
    assign es_valid = valid && ready_go;
    assign handoff  = es_valid && es_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            fs_r <= '0;                    // flushed item never reaches execute
        end else if (fs_valid && allowin) begin
            fs_r <= fs_bus;
        end
    end

    inst_decoder u_decoder (
        .inst       (fs_r.inst),
        .ctrl       (ctrl),
        .uses_rs    (uses_rs),
        .uses_rt    (uses_rt),
        .reserved   (reserved),
        .is_syscall (is_syscall),
        .is_break   (is_break)
    );

    register_file u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .wr     (wb_write)
    );

    operand_forward u_forward (
        .rs         (rs),
        .rt         (rt),
        .uses_rs    (uses_rs),
        .uses_rt    (uses_rt),
        .rf_rs      (rf_rs),
        .rf_rt      (rf_rt),
        .bypass     (bypass),
        .exe_load   (exe_load),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    int_tag_fsm u_int_tag (
        .clk         (clk),
        .reset       (reset),
        .cp0         (cp0),
        .stage_valid (valid),
        .handoff     (handoff),
        .int_tag     (int_tag)
    );

    always_comb begin
        es_bus          = '0;
        es_bus.ctrl     = ctrl;
        es_bus.rs_value = rs_value;
        es_bus.rt_value = rt_value;
        es_bus.pc       = fs_r.pc;
        es_bus.bd       = fs_r.bd;
        es_bus.ex       = fs_r.ex | int_tag | reserved | is_syscall | is_break;
        // fetch fault first, then interrupt, RI, syscall, break
        if (fs_r.ex) begin
            es_bus.exc_code = fs_r.exc_code;
        end else if (int_tag) begin
            es_bus.exc_code = `EXC_INT;
        end else if (reserved) begin
            es_bus.exc_code = `EXC_RI;
        end else if (is_syscall) begin
            es_bus.exc_code = `EXC_SYS;
        end else if (is_break) begin
            es_bus.exc_code = `EXC_BP;
        end
    end

    // a blocked bundle stays in place for the next cycle
    a_hold_blocked: assert property (
        @(posedge clk) disable iff (reset)
        es_valid && !es_allowin && !flush |=> valid && $stable(fs_r)
    ) else $error("blocked decode bundle was not held");

endmodule

`default_nettype wire

/* tb/decode_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_checker (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        es_valid,
    input  wire                        es_allowin,
    input  wire                        allowin,
    input  wire decode_pkg::ds_to_es_t es_bus,
    input  wire                        stall_check
);

    decode_pkg::ds_to_es_t exp_q [$];
    string                 name_q [$];
    decode_pkg::ds_to_es_t exp;
    string                 name;
    string                 current_test = "";
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    test_checks = 0;
    int                    test_errors = 0;

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic push_expect(input string tname, input decode_pkg::ds_to_es_t e);
        name_q.push_back(tname);
        exp_q.push_back(e);
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic compare(input string tname, input string field,
                           input logic [31:0] expv, input logic [31:0] act);
        if (expv !== act) begin
            $display("Error %s: %s expected %h actual %h", tname, field, expv, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test();
        $display("test %s: %0d transfers checked, %0d errors",
                 current_test, test_checks, test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (stall_check && (es_valid || allowin)) begin
                note_failure({"test ", current_test,
                              ": decode did not stall on a load-use hazard"});
            end
            if (es_valid && es_allowin) begin
                if (exp_q.size() == 0) begin
                    note_failure({"test ", current_test,
                                  ": unexpected bundle passed to execute"});
                end else begin
                    exp  = exp_q.pop_front();
                    name = name_q.pop_front();
                    test_checks++;
                    compare(name, "pc", exp.pc, es_bus.pc);
                    compare(name, "alu_op", exp.ctrl.alu_op, es_bus.ctrl.alu_op);
                    compare(name, "load_op", exp.ctrl.load_op, es_bus.ctrl.load_op);
                    compare(name, "src1_is_sa", exp.ctrl.src1_is_sa, es_bus.ctrl.src1_is_sa);
                    compare(name, "src1_is_pc", exp.ctrl.src1_is_pc, es_bus.ctrl.src1_is_pc);
                    compare(name, "src2_sel", exp.ctrl.src2_sel, es_bus.ctrl.src2_sel);
                    compare(name, "src2_is_8", exp.ctrl.src2_is_8, es_bus.ctrl.src2_is_8);
                    compare(name, "gr_we", exp.ctrl.gr_we, es_bus.ctrl.gr_we);
                    compare(name, "mem_we", exp.ctrl.mem_we, es_bus.ctrl.mem_we);
                    compare(name, "dest", exp.ctrl.dest, es_bus.ctrl.dest);
                    compare(name, "imm", exp.ctrl.imm, es_bus.ctrl.imm);
                    compare(name, "rs_value", exp.rs_value, es_bus.rs_value);
                    compare(name, "rt_value", exp.rt_value, es_bus.rt_value);
                    compare(name, "bd", exp.bd, es_bus.bd);
                    compare(name, "ex", exp.ex, es_bus.ex);
                    if (exp.ex) begin
                        compare(name, "exc_code", exp.exc_code, es_bus.exc_code);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/decode_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "decode_consts.svh"

module decode_stage_tb;

    logic                   clk;
    logic                   reset;
    logic                   fs_valid;
    decode_pkg::fetch_bus_t fs_bus;
    logic                   allowin;
    logic                   es_allowin;
    logic                   es_valid;
    decode_pkg::ds_to_es_t  es_bus;
    decode_pkg::wb_write_t  wb_write;
    decode_pkg::bypass_t    bypass [`NUM_BYPASS];
    logic                   exe_load;
    decode_pkg::cp0_int_t   cp0;
    logic                   flush;

    logic                   stall_check;   // checker expects a load-use stall
    logic                   hold_low;      // force es_allowin low
    logic                   rand_mode;     // random es_allowin gaps
    string                  lines [$];
    int                     limit;
    int                     cycles;

    decode_stage DUT (
        .clk        (clk),
        .reset      (reset),
        .fs_valid   (fs_valid),
        .fs_bus     (fs_bus),
        .allowin    (allowin),
        .es_allowin (es_allowin),
        .es_valid   (es_valid),
        .es_bus     (es_bus),
        .wb_write   (wb_write),
        .bypass     (bypass),
        .exe_load   (exe_load),
        .cp0        (cp0),
        .flush      (flush)
    );

    decode_checker chk (
        .clk         (clk),
        .reset       (reset),
        .es_valid    (es_valid),
        .es_allowin  (es_allowin),
        .allowin     (allowin),
        .es_bus      (es_bus),
        .stall_check (stall_check)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // downstream ready changes 1 ns after the edge
    initial begin
        es_allowin = 1'b1;
        void'($urandom(20891));
        forever begin
            @(posedge clk);
            #1;
            es_allowin = hold_low ? 1'b0 : (rand_mode ? ($urandom % 4 != 0) : 1'b1);
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run went past %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

    task automatic wait_drained();
        while (chk.pending() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // mode flags change at the falling edge, away from the driver
    task automatic set_allowin_mode(input logic hold, input logic rnd);
        @(negedge clk);
        hold_low  = hold;
        rand_mode = rnd;
        @(posedge clk);
        #1;
    endtask

    task automatic send_inst(input logic [31:0] inst, input logic ex, input logic [4:0] code,
                             input logic [31:0] pc);
        logic accepted;
        fs_valid        = 1'b1;
        fs_bus          = '0;
        fs_bus.inst     = inst;
        fs_bus.pc       = pc;
        fs_bus.bd       = pc[2];         // delay slot flag toggles with the pc
        fs_bus.ex       = ex;
        fs_bus.exc_code = code;
        do begin
            @(negedge clk);
            accepted = allowin;
            @(posedge clk);
            #1;
        end while (!accepted);
        fs_valid = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        wb_write = '{we: 1'b1, waddr: addr, wdata: data};
        @(posedge clk);
        #1;
        wb_write = '0;
    endtask

    task automatic run_line(input string line, inout logic [31:0] pc);
        string                 tname;
        string                 cmd;
        logic [31:0]           arg [12];
        decode_pkg::ds_to_es_t e;
        int                    n;
        n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h", tname, cmd,
                    arg[0], arg[1], arg[2], arg[3], arg[4], arg[5],
                    arg[6], arg[7], arg[8], arg[9], arg[10], arg[11]);
        if (tname != chk.current_test) begin
            wait_drained();
            if (chk.current_test != "") begin
                chk.end_test();
            end
            chk.current_test = tname;
        end
        if (cmd == "I" && n != 14) begin
            chk.note_failure({"short instruction line in the stimulus: ", line});
        end else if (cmd == "I") begin
            e                 = '0;
            e.ctrl.alu_op     = arg[3][`ALU_OP_WD-1:0];
            e.ctrl.load_op    = (arg[0][31:26] == `OP_LW);
            e.ctrl.src1_is_sa = arg[3][`ALU_SLL] | arg[3][`ALU_SRL] | arg[3][`ALU_SRA];
            e.ctrl.src1_is_pc = (arg[0][31:26] == `OP_JAL);
            e.ctrl.src2_sel   = arg[4][1:0];
            e.ctrl.src2_is_8  = (arg[0][31:26] == `OP_JAL);
            e.ctrl.gr_we      = arg[5][0];
            e.ctrl.mem_we     = arg[6][0];
            e.ctrl.dest       = arg[7][4:0];
            e.ctrl.imm        = arg[0][15:0];
            e.rs_value        = arg[8];
            e.rt_value        = arg[9];
            e.pc              = pc;
            e.bd              = pc[2];
            e.ex              = arg[10][0];
            e.exc_code        = arg[11][4:0];
            chk.push_expect(tname, e);
            send_inst(arg[0], arg[1][0], arg[2][4:0], pc);
            pc = pc + 4;
        end else if (cmd == "W") begin
            wait_drained();
            write_reg(arg[0][4:0], arg[1]);
        end else if (cmd == "B") begin
            wait_drained();
            bypass[arg[0]] = '{dest: arg[1][4:0], result: arg[2]};
        end else if (cmd == "L") begin
            exe_load = arg[0][0];
        end else if (cmd == "H") begin
            stall_check = 1'b1;
            repeat (arg[0]) begin
                @(posedge clk);
                #1;
            end
            stall_check = 1'b0;
        end else if (cmd == "C") begin
            wait_drained();
            cp0 = '{ie: arg[0][0], exl: arg[1][0], im: arg[2][7:0], ip: arg[3][7:0]};
            @(posedge clk);
            #1;
        end else if (cmd == "R") begin
            wait_drained();
            set_allowin_mode(1'b0, arg[0][0]);
        end else if (cmd == "F") begin
            wait_drained();
            set_allowin_mode(1'b1, 1'b0);
            send_inst(arg[0], 1'b0, 5'd0, pc);   // held, then dropped
            pc    = pc + 4;
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
            set_allowin_mode(1'b0, 1'b0);
        end else begin
            chk.note_failure({"unknown stimulus command in line: ", line});
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [31:0] pc;
        reset       = 1'b1;
        fs_valid    = 1'b0;
        fs_bus      = '0;
        wb_write    = '0;
        exe_load    = 1'b0;
        cp0         = '0;
        flush       = 1'b0;
        stall_check = 1'b0;
        hold_low    = 1'b0;
        rand_mode   = 1'b0;
        for (int i = 0; i < `NUM_BYPASS; i++) begin
            bypass[i] = '0;
        end
        pc = 32'hbfc0_0000;

        fd = $fopen("tb/decode_stimulus.txt", "r");
        if (fd == 0) begin
            chk.note_failure("could not open the stimulus file");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        limit = 20 * lines.size() + 100;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        foreach (lines[i]) begin
            run_line(lines[i], pc);
        end
        wait_drained();
        repeat (4) @(posedge clk);    // catch any late extra transfer
        if (chk.current_test != "") begin
            chk.end_test();
        end

        $display("%0d tests, %0d failed, %0d errors",
                 chk.tests_run, chk.tests_failed, chk.errors);
        if (chk.errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/decode_stimulus.txt */
# test cmd | I: inst fs_ex fs_code alu_op src2 gr_we mem_we dest rs rt ex code (hex)
# W addr data | B idx dest result | L exe_load | H cycles | C ie exl im ip | R rand | F inst
t1_decode I 00221821 0 0 001 0 1 0 03 0 0 0 0
t1_decode I 00222023 0 0 002 0 1 0 04 0 0 0 0
t1_decode I 0022282a 0 0 004 0 1 0 05 0 0 0 0
t1_decode I 0022302b 0 0 008 0 1 0 06 0 0 0 0
t1_decode I 00223824 0 0 010 0 1 0 07 0 0 0 0
t1_decode I 00224025 0 0 040 0 1 0 08 0 0 0 0
t1_decode I 00224826 0 0 080 0 1 0 09 0 0 0 0
t1_decode I 00225027 0 0 020 0 1 0 0a 0 0 0 0
t1_decode I 00025900 0 0 100 0 1 0 0b 0 0 0 0
t1_decode I 00026102 0 0 200 0 1 0 0c 0 0 0 0
t1_decode I 00026903 0 0 400 0 1 0 0d 0 0 0 0
t1_decode I 242e0010 0 0 001 2 1 0 0e 0 0 0 0
t1_decode I 3c0f1234 0 0 800 1 1 0 0f 0 0 0 0
t1_decode I 8c300008 0 0 001 2 1 0 10 0 0 0 0
t1_decode I ac220004 0 0 001 2 0 1 00 0 0 0 0
t1_decode I 10220003 0 0 000 0 0 0 00 0 0 0 0
t1_decode I 14220003 0 0 000 0 0 0 00 0 0 0 0
t1_decode I 0c000100 0 0 001 0 1 0 1f 0 0 0 0
t1_decode I 00200008 0 0 000 0 0 0 00 0 0 0 0
t2_regfile W 01 11111111
t2_regfile W 02 22222222
t2_regfile W 00 deadbeef
t2_regfile I 00221821 0 0 001 0 1 0 03 11111111 22222222 0 0
t2_regfile I 00021821 0 0 001 0 1 0 03 00000000 22222222 0 0
t3_forward B 2 01 33333333
t3_forward B 1 01 44444444
t3_forward B 0 01 55555555
t3_forward I 00221821 0 0 001 0 1 0 03 55555555 22222222 0 0
t3_forward B 0 00 00000000
t3_forward I 00221821 0 0 001 0 1 0 03 44444444 22222222 0 0
t3_forward B 1 00 00000000
t3_forward I 00221821 0 0 001 0 1 0 03 33333333 22222222 0 0
t3_forward B 2 00 00000000
t3_forward B 0 00 66666666
t3_forward I 00021821 0 0 001 0 1 0 03 00000000 22222222 0 0
t3_forward B 0 00 00000000
t4_load B 0 01 55555555
t4_load L 1
t4_load I 00221821 0 0 001 0 1 0 03 55555555 22222222 0 0
t4_load H 3
t4_load L 0
t4_load B 0 00 00000000
t4_random R 1
t4_random I 00221821 0 0 001 0 1 0 03 11111111 22222222 0 0
t4_random I 00222023 0 0 002 0 1 0 04 11111111 22222222 0 0
t4_random I 00223824 0 0 010 0 1 0 07 11111111 22222222 0 0
t4_random I 00224025 0 0 040 0 1 0 08 11111111 22222222 0 0
t4_random I 00224826 0 0 080 0 1 0 09 11111111 22222222 0 0
t4_random R 0
t5_except I fc000000 0 0 000 0 0 0 00 0 0 1 0a
t5_except I 0000000c 0 0 000 0 0 0 00 0 0 1 08
t5_except I 0000000d 0 0 000 0 0 0 00 0 0 1 09
t5_except I 0000000c 1 04 000 0 0 0 00 0 0 1 04
t5_except I fc000000 1 05 000 0 0 0 00 0 0 1 05
t6_int C 1 0 01 01
t6_int I 00221821 0 0 001 0 1 0 03 11111111 22222222 1 00
t6_int I 00222023 0 0 002 0 1 0 04 11111111 22222222 0 0
t6_int C 1 0 01 00
t6_int I 00223824 0 0 010 0 1 0 07 11111111 22222222 0 0
t6_flush F 00224025
t6_flush I 00221821 0 0 001 0 1 0 03 11111111 22222222 0 0

/* filelist.f */
+incdir+logic
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/register_file.sv
logic/operand_forward.sv
logic/int_tag_fsm.sv
logic/decode_stage.sv
tb/decode_checker.sv
tb/decode_stage_tb.sv
